//--- source/exu_pkg.sv
package exu_pkg;

    // ALU operation select
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // Operand A source
    typedef enum logic [1:0] {
        SRC_A_PC   = 2'd0,
        SRC_A_ZERO = 2'd1,
        SRC_A_RS1  = 2'd2
    } src_a_e;

    // Operand B source
    typedef enum logic [1:0] {
        SRC_B_IMM  = 2'd0,
        SRC_B_FOUR = 2'd1,
        SRC_B_RS2  = 2'd2
    } src_b_e;

    // Where a register value comes from
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_LSU  = 2'd1,
        FWD_EXU  = 2'd2
    } fwd_e;

    // Branch compare kind
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } br_cond_e;

    // Unconditional control transfer kind
    typedef enum logic [1:0] {
        JUMP_NONE = 2'd0,
        JUMP_JAL  = 2'd1,
        JUMP_JALR = 2'd2,
        JUMP_TRAP = 2'd3
    } jump_e;

    // CSR read-modify-write kind
    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_e;

    // Memory access, decoded by the load/store unit
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

    // System flags carried down the pipe
    typedef enum logic [1:0] {
        SYS_NONE   = 2'd0,
        SYS_ECALL  = 2'd1,
        SYS_MRET   = 2'd2,
        SYS_EBREAK = 2'd3
    } sys_op_e;

endpackage

//--- source/exu_operand_if.sv
`timescale 1ns/1ps

interface exu_operand_if #(
    parameter int XLEN = 32
);

    // Register values after forwarding
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;

    // ALU operands after source selection
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;

    // Producer side, the operand mux
    modport source (
        output rs1_val,
        output rs2_val,
        output op_a,
        output op_b
    );

    // ALU needs both operands and both register values
    modport alu (
        input rs1_val,
        input rs2_val,
        input op_a,
        input op_b
    );

    // Redirect and pipe register only look at register values
    modport sink (
        input rs1_val,
        input rs2_val
    );

endinterface

//--- source/operand_select.sv
`timescale 1ns/1ps

module operand_select #(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0]  rs1_data,
    input  logic [XLEN-1:0]  rs2_data,
    input  logic [XLEN-1:0]  lsu_fwd_data,
    input  logic [XLEN-1:0]  exu_fwd_data,
    input  logic [XLEN-1:0]  pc,
    input  logic [XLEN-1:0]  imm,
    input  exu_pkg::fwd_e    fwd_rs1,
    input  exu_pkg::fwd_e    fwd_rs2,
    input  exu_pkg::src_a_e  src_a,
    input  exu_pkg::src_b_e  src_b,
    exu_operand_if.source    ops
);
    import exu_pkg::*;

    // Same forwarding rule for both source registers
    function automatic logic [XLEN-1:0] pick_fwd(
        input fwd_e            sel,
        input logic [XLEN-1:0] rf_val
    );
        logic [XLEN-1:0] val;
        case (sel)
            // Load result or older ALU result from the LSU stage
            FWD_LSU: val = lsu_fwd_data;
            // Our own output register, held or not
            FWD_EXU: val = exu_fwd_data;
            default: val = rf_val;
        endcase
        return val;
    endfunction

    assign ops.rs1_val = pick_fwd(fwd_rs1, rs1_data);
    assign ops.rs2_val = pick_fwd(fwd_rs2, rs2_data);

    // Operand A: auipc/jal use pc, lui uses zero
    always_comb begin
        case (src_a)
            SRC_A_ZERO: ops.op_a = '0;
            SRC_A_RS1:  ops.op_a = ops.rs1_val;
            default:    ops.op_a = pc;
        endcase
    end

    // Operand B: link address needs the constant four
    always_comb begin
        case (src_b)
            SRC_B_FOUR: ops.op_b = XLEN'(4);
            SRC_B_RS2:  ops.op_b = ops.rs2_val;
            default:    ops.op_b = imm;
        endcase
    end

endmodule

//--- source/exu_alu.sv
`timescale 1ns/1ps

module exu_alu #(
    parameter int XLEN = 32
) (
    exu_operand_if.alu         ops,
    input  exu_pkg::alu_op_e   alu_op,
    input  exu_pkg::br_cond_e  br_cond,
    output logic [XLEN-1:0]    result,
    output logic               br_taken
);
    import exu_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;
    logic       rs_eq;
    logic       rs_lt;
    logic       rs_ltu;

    // RV32 shifts only look at five bits
    assign shamt = ops.op_b[4:0];

    // Operand compares for slt/sltu
    assign lt_signed   = $signed(ops.op_a) < $signed(ops.op_b);
    assign lt_unsigned = ops.op_a < ops.op_b;

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = ops.op_a + ops.op_b;
            ALU_SUB:    result = ops.op_a - ops.op_b;
            ALU_SLL:    result = ops.op_a << shamt;
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:    result = ops.op_a ^ ops.op_b;
            ALU_SRL:    result = ops.op_a >> shamt;
            // Sign bit fills from the left
            ALU_SRA:    result = $unsigned($signed(ops.op_a) >>> shamt);
            ALU_OR:     result = ops.op_a | ops.op_b;
            ALU_AND:    result = ops.op_a & ops.op_b;
            // lui path, operand B already holds the upper immediate
            ALU_PASS_B: result = ops.op_b;
            default:    result = '0;
        endcase
    end

    // Branch compares use the forwarded registers, not the ALU operands
    assign rs_eq  = ops.rs1_val == ops.rs2_val;
    assign rs_lt  = $signed(ops.rs1_val) < $signed(ops.rs2_val);
    assign rs_ltu = ops.rs1_val < ops.rs2_val;

    always_comb begin
        case (br_cond)
            BR_EQ:   br_taken = rs_eq;
            BR_NE:   br_taken = !rs_eq;
            BR_LT:   br_taken = rs_lt;
            BR_GE:   br_taken = !rs_lt;
            BR_LTU:  br_taken = rs_ltu;
            BR_GEU:  br_taken = !rs_ltu;
            default: br_taken = 1'b0;
        endcase
    end

    // Decode must never hand over an unknown opcode
    always_comb begin
        a_alu_op_known: assert final (!$isunknown(alu_op))
            else $error("exu_alu: alu_op is unknown");
    end

endmodule

//--- source/redirect_unit.sv
`timescale 1ns/1ps

module redirect_unit #(
    parameter int XLEN = 32
) (
    exu_operand_if.sink        ops,
    input  logic [XLEN-1:0]    pc,
    input  logic [XLEN-1:0]    imm,
    input  logic [XLEN-1:0]    trap_target,
    input  exu_pkg::jump_e     jump,
    input  logic               br_taken,
    input  logic               accept,
    output logic               redirect_valid,
    output logic               flush,
    output logic [XLEN-1:0]    next_pc
);
    import exu_pkg::*;

    logic [XLEN-1:0] pc_rel_target;
    logic [XLEN-1:0] jalr_sum;
    logic            transfer;

    // jal and taken branches share one adder
    assign pc_rel_target = pc + imm;
    assign jalr_sum      = ops.rs1_val + imm;

    always_comb begin
        case (jump)
            // ecall/mret, CSR file supplies mtvec or mepc
            JUMP_TRAP: next_pc = trap_target;
            // Spec drops bit 0 of the jalr sum
            JUMP_JALR: next_pc = {jalr_sum[XLEN-1:1], 1'b0};
            JUMP_JAL:  next_pc = pc_rel_target;
            default: begin
                if (br_taken) begin
                    next_pc = pc_rel_target;
                end else begin
                    next_pc = pc + XLEN'(4);
                end
            end
        endcase
    end

    // Any jump, or a taken branch, leaves the sequential path
    assign transfer = (jump != JUMP_NONE) || br_taken;

    // Only meaningful in the cycle decode hands the instruction over
    assign redirect_valid = accept && transfer;
    // younger instructions in fetch/decode are wrong-path
    assign flush          = accept && transfer;

    // Fetch must get a real target on every redirect
    always_comb begin
        a_target_known: assert final (!(redirect_valid === 1'b1 && $isunknown(next_pc)))
            else $error("redirect_unit: redirect with unknown target");
    end

endmodule

//--- source/exu_pipe_reg.sv
`timescale 1ns/1ps

module exu_pipe_reg #(
    parameter int XLEN = 32
) (
    input  logic               clock,
    input  logic               rstn,
    input  logic               in_valid,
    output logic               in_ready,
    output logic               out_valid,
    input  logic               out_ready,
    exu_operand_if.sink        ops,
    input  logic [XLEN-1:0]    result_in,
    input  logic [XLEN-1:0]    pc_in,
    input  logic [XLEN-1:0]    next_pc_in,
    input  logic [XLEN-1:0]    csr_rdata,
    input  logic [4:0]         rd_in,
    input  exu_pkg::mem_op_e   mem_op_in,
    input  exu_pkg::sys_op_e   sys_op_in,
    input  exu_pkg::csr_op_e   csr_op_in,
    input  logic               reg_wen_in,
    output logic [XLEN-1:0]    out_result,
    output logic [XLEN-1:0]    out_store_data,
    output logic [XLEN-1:0]    out_pc,
    output logic [XLEN-1:0]    out_dnpc,
    output logic [XLEN-1:0]    out_csr_wdata,
    output logic [4:0]         out_rd,
    output exu_pkg::mem_op_e   out_mem_op,
    output exu_pkg::sys_op_e   out_sys_op,
    output exu_pkg::csr_op_e   out_csr_op,
    output logic               out_reg_wen
);
    import exu_pkg::*;

    logic            accept;
    logic [XLEN-1:0] csr_wdata;

    // Room when empty, or when the held item leaves this cycle
    assign in_ready = out_ready || !out_valid;
    assign accept   = in_valid && in_ready;

    // New CSR value from rs1 and the old CSR contents
    always_comb begin
        case (csr_op_in)
            CSR_WRITE: csr_wdata = ops.rs1_val;
            CSR_SET:   csr_wdata = csr_rdata | ops.rs1_val;
            CSR_CLEAR: csr_wdata = csr_rdata & ~ops.rs1_val;
            default:   csr_wdata = '0;
        endcase
    end

    // Valid flag, set on accept and cleared once the LSU takes it
    always_ff @(posedge clock) begin
        if (rstn) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Payload, only loaded on accept
    always_ff @(posedge clock) begin
        if (rstn) begin
            out_result     <= '0;
            out_store_data <= '0;
            out_pc         <= '0;
            out_dnpc       <= '0;
            out_csr_wdata  <= '0;
            out_rd         <= '0;
            out_mem_op     <= MEM_NONE;
            out_sys_op     <= SYS_NONE;
            out_csr_op     <= CSR_NONE;
            out_reg_wen    <= 1'b0;
        end else if (accept) begin
            out_result     <= result_in;
            // Store data is the forwarded rs2
            out_store_data <= ops.rs2_val;
            out_pc         <= pc_in;
            out_dnpc       <= next_pc_in;
            out_csr_wdata  <= csr_wdata;
            out_rd         <= rd_in;
            out_mem_op     <= mem_op_in;
            out_sys_op     <= sys_op_in;
            out_csr_op     <= csr_op_in;
            out_reg_wen    <= reg_wen_in;
        end
    end

    // Decode stalled, so the offered instruction must wait unchanged
    a_hold_on_stall: assert property (
        @(posedge clock) disable iff (rstn)
        in_valid && !in_ready |=> in_valid && $stable({pc_in, rd_in, mem_op_in,
            sys_op_in, csr_op_in, reg_wen_in})
    ) else $error("exu_pipe_reg: decode payload changed under back-pressure");

endmodule

//--- source/exec_stage.sv
`timescale 1ns/1ps

module exec_stage #(
    parameter int XLEN = 32
) (
    input  logic               clock,
    input  logic               rstn,
    // Decode side
    input  logic               in_valid,
    output logic               in_ready,
    input  logic [XLEN-1:0]    rs1_data,
    input  logic [XLEN-1:0]    rs2_data,
    input  logic [XLEN-1:0]    imm,
    input  logic [XLEN-1:0]    pc,
    input  logic [XLEN-1:0]    csr_rdata,
    input  logic [4:0]         rd,
    input  exu_pkg::fwd_e      fwd_rs1,
    input  exu_pkg::fwd_e      fwd_rs2,
    input  exu_pkg::src_a_e    src_a,
    input  exu_pkg::src_b_e    src_b,
    input  exu_pkg::alu_op_e   alu_op,
    input  exu_pkg::br_cond_e  br_cond,
    input  exu_pkg::jump_e     jump,
    input  exu_pkg::csr_op_e   csr_op,
    input  exu_pkg::mem_op_e   mem_op,
    input  exu_pkg::sys_op_e   sys_op,
    input  logic               reg_wen,
    input  logic [XLEN-1:0]    lsu_fwd_data,
    // Fetch side
    output logic               redirect_valid,
    output logic [XLEN-1:0]    redirect_pc,
    output logic               flush,
    // Load/store side
    output logic               out_valid,
    input  logic               out_ready,
    output logic [XLEN-1:0]    out_result,
    output logic [XLEN-1:0]    out_store_data,
    output logic [XLEN-1:0]    out_pc,
    output logic [XLEN-1:0]    out_dnpc,
    output logic [XLEN-1:0]    out_csr_wdata,
    output logic [4:0]         out_rd,
    output exu_pkg::mem_op_e   out_mem_op,
    output exu_pkg::sys_op_e   out_sys_op,
    output exu_pkg::csr_op_e   out_csr_op,
    output logic               out_reg_wen
);

    logic            accept;
    logic            br_taken;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] next_pc;

    exu_operand_if #(.XLEN(XLEN)) ops ();

    // Decode handshake completes this cycle
    assign accept = in_valid && in_ready;

    // Target is only driven out while a redirect can happen
    assign redirect_pc = accept ? next_pc : '0;

    // out_result doubles as the EXU forwarding source
    operand_select #(.XLEN(XLEN)) u_operand_select (
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .lsu_fwd_data (lsu_fwd_data),
        .exu_fwd_data (out_result),
        .pc           (pc),
        .imm          (imm),
        .fwd_rs1      (fwd_rs1),
        .fwd_rs2      (fwd_rs2),
        .src_a        (src_a),
        .src_b        (src_b),
        .ops          (ops.source)
    );

    exu_alu #(.XLEN(XLEN)) u_alu (
        .ops      (ops.alu),
        .alu_op   (alu_op),
        .br_cond  (br_cond),
        .result   (alu_result),
        .br_taken (br_taken)
    );

    // Trap target arrives on the CSR read port
    redirect_unit #(.XLEN(XLEN)) u_redirect_unit (
        .ops            (ops.sink),
        .pc             (pc),
        .imm            (imm),
        .trap_target    (csr_rdata),
        .jump           (jump),
        .br_taken       (br_taken),
        .accept         (accept),
        .redirect_valid (redirect_valid),
        .flush          (flush),
        .next_pc        (next_pc)
    );

    exu_pipe_reg #(.XLEN(XLEN)) u_pipe_reg (
        .clock          (clock),
        .rstn           (rstn),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .ops            (ops.sink),
        .result_in      (alu_result),
        .pc_in          (pc),
        .next_pc_in     (next_pc),
        .csr_rdata      (csr_rdata),
        .rd_in          (rd),
        .mem_op_in      (mem_op),
        .sys_op_in      (sys_op),
        .csr_op_in      (csr_op),
        .reg_wen_in     (reg_wen),
        .out_result     (out_result),
        .out_store_data (out_store_data),
        .out_pc         (out_pc),
        .out_dnpc       (out_dnpc),
        .out_csr_wdata  (out_csr_wdata),
        .out_rd         (out_rd),
        .out_mem_op     (out_mem_op),
        .out_sys_op     (out_sys_op),
        .out_csr_op     (out_csr_op),
        .out_reg_wen    (out_reg_wen)
    );

endmodule

//--- tests/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Register value after the forwarding choice made by decode
function automatic logic [XLEN-1:0] forwarded_value(
    input fwd_e            sel,
    input logic [XLEN-1:0] rf_val,
    input logic [XLEN-1:0] lsu_val,
    input logic [XLEN-1:0] exu_val
);
    case (sel)
        FWD_LSU: return lsu_val;
        // Whatever sits in the output register right now
        FWD_EXU: return exu_val;
        default: return rf_val;
    endcase
endfunction

function automatic logic [XLEN-1:0] operand_a(
    input src_a_e          sel,
    input logic [XLEN-1:0] pc_val,
    input logic [XLEN-1:0] rs1_val
);
    case (sel)
        SRC_A_ZERO: return '0;
        SRC_A_RS1:  return rs1_val;
        default:    return pc_val;
    endcase
endfunction

function automatic logic [XLEN-1:0] operand_b(
    input src_b_e          sel,
    input logic [XLEN-1:0] imm_val,
    input logic [XLEN-1:0] rs2_val
);
    case (sel)
        SRC_B_FOUR: return XLEN'(4);
        SRC_B_RS2:  return rs2_val;
        default:    return imm_val;
    endcase
endfunction

// Two's complement less-than from the sign bits
function automatic logic signed_less(
    input logic [XLEN-1:0] a,
    input logic [XLEN-1:0] b
);
    // Different signs, so the negative one is smaller
    return (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b);
endfunction

function automatic logic [XLEN-1:0] alu_expect(
    input alu_op_e         op,
    input logic [XLEN-1:0] a,
    input logic [XLEN-1:0] b
);
    logic [4:0]      sh;
    logic [XLEN-1:0] fill;
    sh = b[4:0];
    // Bits that an arithmetic right shift fills with the sign
    fill = a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0;
    case (op)
        ALU_ADD:    return a + b;
        ALU_SUB:    return a + ~b + XLEN'(1);
        ALU_SLL:    return a << sh;
        ALU_SLT:    return XLEN'(signed_less(a, b));
        ALU_SLTU:   return XLEN'(a < b);
        ALU_XOR:    return a ^ b;
        ALU_SRL:    return a >> sh;
        ALU_SRA:    return (a >> sh) | fill;
        ALU_OR:     return a | b;
        ALU_AND:    return a & b;
        ALU_PASS_B: return b;
        default:    return '0;
    endcase
endfunction

function automatic logic branch_taken(
    input br_cond_e        cond,
    input logic [XLEN-1:0] rs1_val,
    input logic [XLEN-1:0] rs2_val
);
    case (cond)
        BR_EQ:   return rs1_val == rs2_val;
        BR_NE:   return rs1_val != rs2_val;
        BR_LT:   return signed_less(rs1_val, rs2_val);
        BR_GE:   return !signed_less(rs1_val, rs2_val);
        BR_LTU:  return rs1_val < rs2_val;
        BR_GEU:  return rs1_val >= rs2_val;
        default: return 1'b0;
    endcase
endfunction

// Next PC after the instruction, taken or sequential
function automatic logic [XLEN-1:0] target_pc(
    input jump_e           kind,
    input logic            taken,
    input logic [XLEN-1:0] pc_val,
    input logic [XLEN-1:0] imm_val,
    input logic [XLEN-1:0] rs1_val,
    input logic [XLEN-1:0] trap_val
);
    case (kind)
        JUMP_TRAP: return trap_val;
        // Low bit of the jalr sum is dropped
        JUMP_JALR: return (rs1_val + imm_val) & ~XLEN'(1);
        JUMP_JAL:  return pc_val + imm_val;
        default:   return taken ? pc_val + imm_val : pc_val + XLEN'(4);
    endcase
endfunction

function automatic logic [XLEN-1:0] csr_new_value(
    input csr_op_e         op,
    input logic [XLEN-1:0] rs1_val,
    input logic [XLEN-1:0] old_val
);
    case (op)
        CSR_WRITE: return rs1_val;
        CSR_SET:   return old_val | rs1_val;
        CSR_CLEAR: return old_val & ~rs1_val;
        default:   return '0;
    endcase
endfunction

`endif

//--- tests/exec_stage_tb.sv
`timescale 1ns/1ps

module exec_stage_tb;
    import exu_pkg::*;

    localparam int XLEN         = 32;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_CYCLES   = 400;
    // Half the run again covers reset and the last transfers
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 2;

    `include "exec_model.svh"

    // Everything the output register holds
    typedef struct {
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] store_data;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] dnpc;
        logic [XLEN-1:0] csr_wdata;
        logic [4:0]      rd;
        mem_op_e         mem_op;
        sys_op_e         sys_op;
        csr_op_e         csr_op;
        logic            reg_wen;
    } payload_t;

    logic            clock = 1'b0;
    logic            rstn;
    logic            in_valid, in_ready, out_valid, out_ready, reg_wen;
    logic            redirect_valid, flush, out_reg_wen;
    logic [XLEN-1:0] rs1_data, rs2_data, imm, pc, csr_rdata, lsu_fwd_data;
    logic [XLEN-1:0] redirect_pc, out_result, out_store_data, out_pc, out_dnpc;
    logic [XLEN-1:0] out_csr_wdata;
    logic [4:0]      rd, out_rd;
    fwd_e            fwd_rs1, fwd_rs2;
    src_a_e          src_a;
    src_b_e          src_b;
    alu_op_e         alu_op;
    br_cond_e        br_cond;
    jump_e           jump;
    csr_op_e         csr_op, out_csr_op;
    mem_op_e         mem_op, out_mem_op;
    sys_op_e         sys_op, out_sys_op;

    // Model state
    payload_t        held;
    logic            exp_valid;
    logic            decode_stall;
    int              cycle_count = 0;
    logic [31:0]     lfsr_state = 32'h7ea1;

    exec_stage #(.XLEN(XLEN)) u_exec_stage (.*);

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped on failure");
    endtask

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        abort_run();
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic payload_t empty_payload();
        payload_t p;
        p.result     = '0;
        p.store_data = '0;
        p.pc         = '0;
        p.dnpc       = '0;
        p.csr_wdata  = '0;
        p.rd         = '0;
        p.mem_op     = MEM_NONE;
        p.sys_op     = SYS_NONE;
        p.csr_op     = CSR_NONE;
        p.reg_wen    = 1'b0;
        return p;
    endfunction

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp)
            report_error($sformatf("%s is %h, expected %h", name, got, exp));
    endtask

    task automatic check_rd(input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp)
            report_error($sformatf("out_rd is %0d, expected %0d", got, exp));
    endtask

    task automatic check_mem_op(input mem_op_e got, input mem_op_e exp);
        if (got !== exp)
            report_error($sformatf("out_mem_op is %s, expected %s", got.name(), exp.name()));
    endtask

    task automatic check_sys_op(input sys_op_e got, input sys_op_e exp);
        if (got !== exp)
            report_error($sformatf("out_sys_op is %s, expected %s", got.name(), exp.name()));
    endtask

    task automatic check_csr_op(input csr_op_e got, input csr_op_e exp);
        if (got !== exp)
            report_error($sformatf("out_csr_op is %s, expected %s", got.name(), exp.name()));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_error($sformatf("%s is %b, expected %b", name, got, exp));
    endtask

    task automatic match_payload(input payload_t p);
        check_word("out_result", out_result, p.result);
        check_word("out_store_data", out_store_data, p.store_data);
        check_word("out_pc", out_pc, p.pc);
        check_word("out_dnpc", out_dnpc, p.dnpc);
        check_word("out_csr_wdata", out_csr_wdata, p.csr_wdata);
        check_rd(out_rd, p.rd);
        check_mem_op(out_mem_op, p.mem_op);
        check_sys_op(out_sys_op, p.sys_op);
        check_csr_op(out_csr_op, p.csr_op);
        check_bit("out_reg_wen", out_reg_wen, p.reg_wen);
    endtask

    task automatic randomize_inputs();
        rs1_data = rand_bits(32);
        // Equal registers now and then so EQ/GE compares go both ways
        rs2_data = rand_bits(1) ? rs1_data : rand_bits(32);
        imm          = rand_bits(32);
        pc           = rand_bits(30) << 2;
        csr_rdata    = rand_bits(32);
        lsu_fwd_data = rand_bits(32);
        rd           = 5'(rand_bits(5));
        fwd_rs1      = fwd_e'(2'(rand_bits(2) % 3));
        fwd_rs2      = fwd_e'(2'(rand_bits(2) % 3));
        src_a        = src_a_e'(2'(rand_bits(2) % 3));
        src_b        = src_b_e'(2'(rand_bits(2) % 3));
        alu_op       = alu_op_e'(4'(rand_bits(4) % 11));
        br_cond      = br_cond_e'(3'(rand_bits(3) % 7));
        // Half the instructions are no jump at all
        jump         = rand_bits(1) ? JUMP_NONE : jump_e'(2'(rand_bits(2)));
        csr_op       = csr_op_e'(2'(rand_bits(2)));
        mem_op       = mem_op_e'(4'(rand_bits(4) % 9));
        sys_op       = sys_op_e'(2'(rand_bits(2)));
        reg_wen      = rand_bits(1);
        in_valid     = rand_bits(2) != 0;
    endtask

    // Sampled late in the cycle, then the model steps past the next edge
    task automatic evaluate_cycle();
        logic            exp_ready;
        logic            accept;
        logic            taken;
        logic            transfer;
        logic [XLEN-1:0] rs1_val, rs2_val, op_a, op_b, npc;
        match_payload(held);
        check_bit("out_valid", out_valid, exp_valid);
        exp_ready = out_ready || !exp_valid;
        check_bit("in_ready", in_ready, exp_ready);
        accept   = in_valid && exp_ready;
        rs1_val  = forwarded_value(fwd_rs1, rs1_data, lsu_fwd_data, held.result);
        rs2_val  = forwarded_value(fwd_rs2, rs2_data, lsu_fwd_data, held.result);
        op_a     = operand_a(src_a, pc, rs1_val);
        op_b     = operand_b(src_b, imm, rs2_val);
        taken    = branch_taken(br_cond, rs1_val, rs2_val);
        npc      = target_pc(jump, taken, pc, imm, rs1_val, csr_rdata);
        transfer = (jump != JUMP_NONE) || taken;
        check_bit("redirect_valid", redirect_valid, accept && transfer);
        check_bit("flush", flush, accept && transfer);
        check_word("redirect_pc", redirect_pc, accept ? npc : '0);
        if (accept) begin
            held.result     = alu_expect(alu_op, op_a, op_b);
            held.store_data = rs2_val;
            held.pc         = pc;
            held.dnpc       = npc;
            held.csr_wdata  = csr_new_value(csr_op, rs1_val, csr_rdata);
            held.rd         = rd;
            held.mem_op     = mem_op;
            held.sys_op     = sys_op;
            held.csr_op     = csr_op;
            held.reg_wen    = reg_wen;
        end
        exp_valid    = accept || (exp_valid && !out_ready);
        // Decode must hold its offer until it is taken
        decode_stall = in_valid && !exp_ready;
    endtask

    initial begin
        rstn         = 1'b1;
        in_valid     = 1'b0;
        out_ready    = 1'b0;
        rs1_data     = '0;
        rs2_data     = '0;
        imm          = '0;
        pc           = '0;
        csr_rdata    = '0;
        lsu_fwd_data = '0;
        rd           = '0;
        fwd_rs1      = FWD_NONE;
        fwd_rs2      = FWD_NONE;
        src_a        = SRC_A_PC;
        src_b        = SRC_B_IMM;
        alu_op       = ALU_ADD;
        br_cond      = BR_NONE;
        jump         = JUMP_NONE;
        csr_op       = CSR_NONE;
        mem_op       = MEM_NONE;
        sys_op       = SYS_NONE;
        reg_wen      = 1'b0;
        held         = empty_payload();
        exp_valid    = 1'b0;
        decode_stall = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        rstn = 1'b0;
        // Reset values, nothing offered yet
        #28;
        evaluate_cycle();
        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(posedge clock);
            #2;
            out_ready = rand_bits(2) != 0;
            if (!decode_stall)
                randomize_inputs();
            #28;
            evaluate_cycle();
        end
        $display("Test passed");
        $finish;
    end

endmodule

//--- src.f
+incdir+tests
source/exu_pkg.sv
source/exu_operand_if.sv
source/operand_select.sv
source/exu_alu.sv
source/redirect_unit.sv
source/exu_pipe_reg.sv
source/exec_stage.sv
tests/exec_stage_tb.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  - files:
      - source/exu_pkg.sv
      - source/exu_operand_if.sv
      - source/operand_select.sv
      - source/exu_alu.sv
      - source/redirect_unit.sv
      - source/exu_pipe_reg.sv
      - source/exec_stage.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/exec_stage_tb.sv
